// File: cs_registers.f
design/csr_pkg.sv
design/csr_if.sv
design/csr_ctrl.sv
design/machine_csrs.sv
design/debug_csrs.sv
design/perf_counters.sv
design/cs_registers.sv
bench/cs_registers_tb.sv

// File: bench/cs_registers_tb.sv
//////////////////////////////
// csr block testbench
// drives cs_registers, checks reads and outputs against a model
//////////////////////////////

`timescale 1ns/10ps

module cs_registers_tb;

  localparam int CYCLE_LIMIT = 2000;  // all six tests fit in a few hundred cycles
  localparam int WRAP_WAIT   = 5;     // idle cycles after saturation is cleared
  localparam logic [31:0] MSTATUS_RESET = 32'h0000_1800;  // mpp=m only
  localparam logic [31:0] DCSR_RESET    = 32'h4000_0003;  // xdebugver=4, prv=3
  // kept dcsr fields: ebreakm, ebreaks, ebreaku, stepie, cause, step
  localparam logic [31:0] DCSR_KEEP = (32'd1 << 15) | (32'd1 << 13) | (32'd1 << 12) |
                                      (32'd1 << 11) | (32'd7 << 6) | (32'd1 << 2);

  logic clk;
  logic rst_n;
  logic [3:0] core_id_i;
  logic [5:0] cluster_id_i;
  csr_pkg::csr_data_t boot_addr_i;
  logic csr_access_i;
  csr_pkg::csr_addr_t csr_addr_i;
  csr_pkg::csr_data_t csr_wdata_i;
  csr_pkg::csr_op_e csr_op_i;
  csr_pkg::csr_data_t csr_rdata_o;
  csr_pkg::csr_data_t pc_if_i;
  csr_pkg::csr_data_t pc_id_i;
  logic csr_save_if_i, csr_save_id_i, csr_save_cause_i, debug_csr_save_i;
  csr_pkg::exc_cause_t csr_cause_i;
  csr_pkg::dbg_cause_t debug_cause_i;
  logic csr_restore_mret_i, csr_restore_dret_i;
  logic if_valid_i, mem_load_i, mem_store_i, branch_i, branch_taken_i;
  logic m_irq_enable_o, debug_single_step_o, debug_ebreakm_o;
  csr_pkg::csr_data_t mepc_o, depc_o;

  integer seed = 24403;
  int     cycles = 0;
  int     test_errs, tests_run, tests_passed, tests_failed;
  string  test_name;

  // reference state
  logic               m_mie, m_mpie;
  csr_pkg::csr_data_t m_mepc, m_dscratch0, m_dpc;

  cs_registers i_cs_registers (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: no result after %0d cycles", CYCLE_LIMIT);
      $display("Test FAILED");
      $finish;
    end
  end

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic check_eq(input string what, input csr_pkg::csr_data_t exp,
                          input csr_pkg::csr_data_t act);
    assert (act === exp) else begin
      $display("error %s %s: expected %h actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic finish_test();
    tests_run++;
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, test_errs);
    end
  endtask

  // one op, returns the read data seen before the write edge
  task automatic csr_access(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_op_e op,
                            input csr_pkg::csr_data_t operand,
                            output csr_pkg::csr_data_t old);
    @(posedge clk);
    #1;
    csr_access_i = 1'b1;
    csr_addr_i   = addr;
    csr_op_i     = op;
    csr_wdata_i  = operand;
    @(negedge clk);
    old = csr_rdata_o;
    @(posedge clk);  // write lands here
    #1;
    csr_access_i = 1'b0;
    csr_op_i     = csr_pkg::CSR_OP_NONE;
    csr_wdata_i  = '0;
  endtask

  task automatic csr_write(input csr_pkg::csr_addr_t addr, input csr_pkg::csr_data_t data);
    csr_pkg::csr_data_t unused;
    csr_access(addr, csr_pkg::CSR_OP_WRITE, data, unused);
  endtask

  task automatic csr_read(input csr_pkg::csr_addr_t addr, output csr_pkg::csr_data_t data);
    @(posedge clk);
    #1;
    csr_access_i = 1'b1;
    csr_addr_i   = addr;
    csr_op_i     = csr_pkg::CSR_OP_NONE;
    @(negedge clk);
    data = csr_rdata_o;
  endtask

  task automatic read_check(input string what, input csr_pkg::csr_addr_t addr,
                            input csr_pkg::csr_data_t exp);
    csr_pkg::csr_data_t rd;
    csr_read(addr, rd);
    check_eq(what, exp, rd);
  endtask

  // one cycle strobe of the trap inputs
  task automatic trap_pulse(input logic save, input logic dbg, input logic sel_if,
                            input logic mret);
    @(posedge clk);
    #1;
    csr_save_cause_i   = save;
    debug_csr_save_i   = dbg;
    csr_save_if_i      = sel_if;
    csr_save_id_i      = save & ~sel_if;
    csr_restore_mret_i = mret;
    @(posedge clk);
    #1;
    csr_save_cause_i   = 1'b0;
    debug_csr_save_i   = 1'b0;
    csr_save_if_i      = 1'b0;
    csr_save_id_i      = 1'b0;
    csr_restore_mret_i = 1'b0;
  endtask

  // op rule: write, set, clear
  function automatic csr_pkg::csr_data_t merge_ref(input csr_pkg::csr_op_e op,
      input csr_pkg::csr_data_t operand, input csr_pkg::csr_data_t old);
    case (op)
      csr_pkg::CSR_OP_SET:   merge_ref = old | operand;
      csr_pkg::CSR_OP_CLEAR: merge_ref = old & ~operand;
      default:               merge_ref = operand;
    endcase
  endfunction

  function automatic csr_pkg::csr_data_t mstatus_model();
    mstatus_model = MSTATUS_RESET;
    mstatus_model[3] = m_mie;
    mstatus_model[7] = m_mpie;
  endfunction

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    csr_pkg::csr_addr_t addr;
    csr_pkg::csr_op_e   op;
    csr_pkg::csr_data_t operand, old, merged;
    csr_pkg::exc_cause_t cause;
    csr_pkg::dbg_cause_t dcause;
    int n_load, n_br, n_max;

    rst_n = 1'b0;
    core_id_i = $random(seed);
    cluster_id_i = $random(seed);
    boot_addr_i = $random(seed);
    csr_access_i = 1'b0;
    csr_addr_i = '0;
    csr_wdata_i = '0;
    csr_op_i = csr_pkg::CSR_OP_NONE;
    pc_if_i = '0;
    pc_id_i = '0;
    csr_save_if_i = 1'b0;
    csr_save_id_i = 1'b0;
    csr_save_cause_i = 1'b0;
    csr_cause_i = '0;
    debug_csr_save_i = 1'b0;
    debug_cause_i = '0;
    csr_restore_mret_i = 1'b0;
    csr_restore_dret_i = 1'b0;
    {if_valid_i, mem_load_i, mem_store_i, branch_i, branch_taken_i} = '0;
    tests_run = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;

    // 1. reset values
    start_test("reset_values");
    read_check("mstatus", csr_pkg::CSR_MSTATUS, MSTATUS_RESET);
    read_check("misa", csr_pkg::CSR_MISA, 32'h4000_0104);
    read_check("mhartid", csr_pkg::CSR_MHARTID, (32'(cluster_id_i) << 5) | 32'(core_id_i));
    read_check("mtvec", csr_pkg::CSR_MTVEC, boot_addr_i & 32'hFFFF_FF00);
    read_check("dcsr", csr_pkg::CSR_DCSR, DCSR_RESET);
    check_eq("irq_enable", 32'd0, 32'(m_irq_enable_o));
    check_eq("single_step", 32'd0, 32'(debug_single_step_o));
    check_eq("ebreakm", 32'd0, 32'(debug_ebreakm_o));
    finish_test();

    // 2. write/set/clear on three registers
    start_test("csr_ops");
    {m_mie, m_mpie, m_mepc, m_dscratch0} = '0;
    for (int r = 0; r < 3; r++) begin
      for (int o = 1; o <= 3; o++) begin
        addr = (r == 0) ? csr_pkg::CSR_DSCRATCH0 :
               (r == 1) ? csr_pkg::CSR_MEPC : csr_pkg::CSR_MSTATUS;
        op = csr_pkg::csr_op_e'(o);
        operand = $random(seed);
        csr_access(addr, op, operand, old);
        if (r == 0) begin
          check_eq("dscratch0 old", m_dscratch0, old);
          m_dscratch0 = merge_ref(op, operand, m_dscratch0);
          read_check("dscratch0", addr, m_dscratch0);
        end else if (r == 1) begin
          check_eq("mepc old", m_mepc, old);
          m_mepc = merge_ref(op, operand, m_mepc);
          check_eq("mepc_o", m_mepc, mepc_o);
          read_check("mepc", addr, m_mepc);
        end else begin
          check_eq("mstatus old", mstatus_model(), old);
          merged = merge_ref(op, operand, mstatus_model());
          m_mie  = merged[3];  // only mie and mpie are stored
          m_mpie = merged[7];
          check_eq("irq_enable", 32'(m_mie), 32'(m_irq_enable_o));
          read_check("mstatus", addr, mstatus_model());
        end
      end
    end
    finish_test();

    // 3. trap entry and return
    start_test("trap_entry");
    csr_write(csr_pkg::CSR_MSTATUS, 32'h0000_0008);
    m_mie = 1'b1;
    m_mpie = 1'b0;
    pc_if_i = $random(seed);
    pc_id_i = $random(seed);  // must not be picked
    cause = $random(seed);
    csr_cause_i = cause;
    trap_pulse(1'b1, 1'b0, 1'b1, 1'b0);
    m_mepc = pc_if_i;
    m_mpie = m_mie;
    m_mie = 1'b0;
    check_eq("mepc_o", m_mepc, mepc_o);
    check_eq("irq_enable", 32'd0, 32'(m_irq_enable_o));
    read_check("mcause", csr_pkg::CSR_MCAUSE, (32'(cause[5]) << 31) | 32'(cause[4:0]));
    read_check("mstatus after save", csr_pkg::CSR_MSTATUS, mstatus_model());
    trap_pulse(1'b0, 1'b0, 1'b0, 1'b1);  // mret
    m_mie = m_mpie;
    m_mpie = 1'b1;
    check_eq("irq after mret", 32'(m_mie), 32'(m_irq_enable_o));
    read_check("mstatus after mret", csr_pkg::CSR_MSTATUS, mstatus_model());
    pc_id_i = $random(seed);
    dcause = $random(seed);
    debug_cause_i = dcause;
    trap_pulse(1'b1, 1'b1, 1'b0, 1'b0);  // debug entry with id pc
    m_dpc = pc_id_i;
    check_eq("depc_o", m_dpc, depc_o);
    read_check("dcsr cause", csr_pkg::CSR_DCSR, DCSR_RESET | (32'(dcause) << 6));
    check_eq("mepc kept", m_mepc, mepc_o);
    read_check("mstatus kept", csr_pkg::CSR_MSTATUS, mstatus_model());
    finish_test();

    // 4. dcsr field rules and dpc alignment
    start_test("debug_writes");
    csr_write(csr_pkg::CSR_DCSR, 32'hFFFF_FFFF);
    read_check("dcsr ones", csr_pkg::CSR_DCSR, DCSR_RESET | DCSR_KEEP);
    check_eq("single_step", 32'd1, 32'(debug_single_step_o));
    check_eq("ebreakm", 32'd1, 32'(debug_ebreakm_o));
    csr_write(csr_pkg::CSR_DCSR, 32'h0);
    read_check("dcsr zero", csr_pkg::CSR_DCSR, DCSR_RESET);
    check_eq("single_step off", 32'd0, 32'(debug_single_step_o));
    operand = $random(seed);
    csr_write(csr_pkg::CSR_DPC, operand | 32'd1);  // odd, dropped
    check_eq("dpc odd", m_dpc, depc_o);
    m_dpc = operand & ~32'd1;
    csr_write(csr_pkg::CSR_DPC, m_dpc);
    check_eq("dpc even", m_dpc, depc_o);
    finish_test();

    // 5. event counting
    start_test("counting");
    csr_write(csr_pkg::CSR_PCER, (32'd1 << 2) | (32'd1 << 4));  // load, branch
    n_load = 1 + ($random(seed) & 15);
    n_br = 1 + ($random(seed) & 15);
    n_max = (n_load > n_br) ? n_load : n_br;
    for (int k = 0; k < n_max; k++) begin
      @(posedge clk);
      #1;
      mem_load_i  = (k < n_load);
      mem_store_i = (k < n_load);  // store counter is off
      branch_i    = (k < n_br);
    end
    @(posedge clk);
    #1;
    {mem_load_i, mem_store_i, branch_i} = '0;
    // read lands right after the add edge
    read_check("load count", 12'h782, 32'(n_load));
    read_check("branch count", 12'h784, 32'(n_br));
    read_check("store count", 12'h783, 32'd0);
    csr_write(csr_pkg::CSR_PCMR, 32'd2);  // enable off, saturation on
    repeat (4) begin
      @(posedge clk);
      #1;
      mem_load_i = 1'b1;
      branch_i   = 1'b1;
    end
    @(posedge clk);
    #1;
    {mem_load_i, branch_i} = '0;
    repeat (2) @(posedge clk);
    read_check("load held", 12'h782, 32'(n_load));
    read_check("branch held", 12'h784, 32'(n_br));
    finish_test();

    // 6. write-all and saturation
    start_test("saturation");
    csr_write(csr_pkg::CSR_PCER, 32'd1);  // cycle counter only
    csr_write(csr_pkg::CSR_PCCR_ALL, 32'hFFFF_FFFF);
    for (int c = 0; c < 6; c++) begin
      read_check("write all", 12'h780 + 12'(c), 32'hFFFF_FFFF);
    end
    read_check("slot 6", 12'h786, 32'd0);
    read_check("pccr_all read", csr_pkg::CSR_PCCR_ALL, 32'd0);
    csr_write(csr_pkg::CSR_PCMR, 32'd3);
    repeat (4) @(posedge clk);
    read_check("cycle saturated", 12'h780, 32'hFFFF_FFFF);
    csr_write(csr_pkg::CSR_PCMR, 32'd1);  // saturation off
    repeat (WRAP_WAIT) @(posedge clk);
    // first unsaturated add wraps to 0, then one per cycle
    read_check("cycle wrapped", 12'h780, 32'(WRAP_WAIT));
    read_check("load untouched", 12'h782, 32'hFFFF_FFFF);
    finish_test();

    $display("tests run %0d, passed %0d, failed %0d", tests_run, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: design/cs_registers.sv
//////////////////////////////
// csr block top
// machine, debug and perf banks behind one csr port
//////////////////////////////

`timescale 1ns/10ps

module cs_registers (
  input  logic                clk,
  input  logic                rst_n,
  input  logic [3:0]          core_id_i,
  input  logic [5:0]          cluster_id_i,
  input  csr_pkg::csr_data_t  boot_addr_i,
  // csr access port
  input  logic                csr_access_i,
  input  csr_pkg::csr_addr_t  csr_addr_i,
  input  csr_pkg::csr_data_t  csr_wdata_i,
  input  csr_pkg::csr_op_e    csr_op_i,
  output csr_pkg::csr_data_t  csr_rdata_o,
  // trap control
  input  csr_pkg::csr_data_t  pc_if_i,
  input  csr_pkg::csr_data_t  pc_id_i,
  input  logic                csr_save_if_i,
  input  logic                csr_save_id_i,     // id pc is picked unless save_if
  input  logic                csr_save_cause_i,
  input  csr_pkg::exc_cause_t csr_cause_i,
  input  logic                debug_csr_save_i,
  input  csr_pkg::dbg_cause_t debug_cause_i,
  input  logic                csr_restore_mret_i,
  input  logic                csr_restore_dret_i,
  // counter events
  input  logic                if_valid_i,
  input  logic                mem_load_i,
  input  logic                mem_store_i,
  input  logic                branch_i,
  input  logic                branch_taken_i,
  // to the core
  output logic                m_irq_enable_o,
  output csr_pkg::csr_data_t  mepc_o,
  output csr_pkg::csr_data_t  depc_o,
  output logic                debug_single_step_o,
  output logic                debug_ebreakm_o
);

  csr_bus_if csr_bus ();
  trap_if    trap ();

  assign csr_bus.access = csr_access_i;
  assign csr_bus.addr   = csr_addr_i;
  assign csr_bus.op     = csr_op_i;

  csr_ctrl i_csr_ctrl (
    .bus(csr_bus.ctrl), .trap(trap.ctrl),
    .csr_op_i(csr_bus.op), .csr_wdata_i(csr_wdata_i),
    .pc_if_i(pc_if_i), .pc_id_i(pc_id_i),
    .csr_save_if_i(csr_save_if_i), .csr_save_cause_i(csr_save_cause_i),
    .debug_csr_save_i(debug_csr_save_i), .csr_cause_i(csr_cause_i),
    .debug_cause_i(debug_cause_i), .csr_restore_mret_i(csr_restore_mret_i),
    .csr_restore_dret_i(csr_restore_dret_i), .csr_rdata_o(csr_rdata_o)
  );

  machine_csrs i_machine_csrs (
    .clk(clk), .rst_n(rst_n), .bus(csr_bus.machine), .trap(trap.machine),
    .core_id_i(core_id_i), .cluster_id_i(cluster_id_i), .boot_addr_i(boot_addr_i),
    .irq_enable_o(m_irq_enable_o), .mepc_o(mepc_o)
  );

  debug_csrs i_debug_csrs (
    .clk(clk), .rst_n(rst_n), .bus(csr_bus.debug), .trap(trap.debug),
    .depc_o(depc_o), .single_step_o(debug_single_step_o),
    .ebreakm_o(debug_ebreakm_o)
  );

  perf_counters i_perf_counters (
    .clk(clk), .rst_n(rst_n), .bus(csr_bus.perf),
    .if_valid_i(if_valid_i), .mem_load_i(mem_load_i), .mem_store_i(mem_store_i),
    .branch_i(branch_i), .branch_taken_i(branch_taken_i)
  );

endmodule

// File: design/perf_counters.sv
//////////////////////////////
// performance counters
// six event counters with enable and mode regs
//////////////////////////////

`timescale 1ns/10ps

module perf_counters (
  input  logic       clk,
  input  logic       rst_n,
  csr_bus_if.perf    bus,
  input  logic       if_valid_i,
  input  logic       mem_load_i,
  input  logic       mem_store_i,
  input  logic       branch_i,
  input  logic       branch_taken_i
);

  csr_pkg::perf_mask_t events;
  csr_pkg::perf_mask_t pcer_q;   // per counter enable
  logic [1:0]          pcmr_q;   // global enable, saturation
  csr_pkg::perf_mask_t inc_q;    // registered increments
  csr_pkg::csr_data_t  cnt_q [csr_pkg::N_PERF_COUNTERS];

  logic pcer_sel;
  logic pcmr_sel;
  logic pccr_sel;  // whole 0x780..0x79f window
  logic all_sel;

  // event map
  assign events[csr_pkg::CNT_CYCLE]  = 1'b1;
  assign events[csr_pkg::CNT_INSTR]  = if_valid_i;
  assign events[csr_pkg::CNT_LOAD]   = mem_load_i;
  assign events[csr_pkg::CNT_STORE]  = mem_store_i;
  assign events[csr_pkg::CNT_BRANCH] = branch_i;
  assign events[csr_pkg::CNT_TAKEN]  = branch_taken_i;

  //////////////////////////////
  // decode and read
  //////////////////////////////

  always_comb begin
    pcer_sel    = bus.access && bus.addr == csr_pkg::CSR_PCER;
    pcmr_sel    = bus.access && bus.addr == csr_pkg::CSR_PCMR;
    pccr_sel    = bus.access && bus.addr[11:5] == csr_pkg::CSR_PCCR_BASE[11:5];
    all_sel     = pccr_sel && bus.addr == csr_pkg::CSR_PCCR_ALL;
    bus.p_hit   = pcer_sel | pcmr_sel | pccr_sel;
    bus.p_rdata = '0;
    if (pcer_sel) begin
      bus.p_rdata = csr_pkg::csr_data_t'(pcer_q);
    end else if (pcmr_sel) begin
      bus.p_rdata = csr_pkg::csr_data_t'(pcmr_q);
    end else if (pccr_sel) begin
      for (int c = 0; c < csr_pkg::N_PERF_COUNTERS; c++) begin
        if (bus.addr[4:0] == 5'(c)) bus.p_rdata = cnt_q[c];  // upper slots read 0
      end
    end
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pcer_q <= '0;
      pcmr_q <= csr_pkg::PCMR_RESET;
      inc_q  <= '0;
      for (int c = 0; c < csr_pkg::N_PERF_COUNTERS; c++) cnt_q[c] <= '0;
    end else begin
      // one cycle of latency before the add
      inc_q <= events & pcer_q & {csr_pkg::N_PERF_COUNTERS{pcmr_q[csr_pkg::PCMR_EN_BIT]}};
      if (pcer_sel && bus.we) pcer_q <= bus.wdata[csr_pkg::N_PERF_COUNTERS-1:0];
      if (pcmr_sel && bus.we) pcmr_q <= bus.wdata[1:0];
      for (int c = 0; c < csr_pkg::N_PERF_COUNTERS; c++) begin
        if (pccr_sel && bus.we && (all_sel || bus.addr[4:0] == 5'(c))) begin
          cnt_q[c] <= bus.wdata;  // write beats a pending increment
        end else if (inc_q[c] &&
                     !(pcmr_q[csr_pkg::PCMR_SAT_BIT] && cnt_q[c] == '1)) begin
          cnt_q[c] <= cnt_q[c] + 32'd1;
        end
      end
    end
  end

endmodule

// File: design/debug_csrs.sv
//////////////////////////////
// debug csr bank
// dcsr, dpc and two scratch regs
//////////////////////////////

`timescale 1ns/10ps

module debug_csrs (
  input  logic               clk,
  input  logic               rst_n,
  csr_bus_if.debug           bus,
  trap_if.debug              trap,
  output csr_pkg::csr_data_t depc_o,
  output logic               single_step_o,
  output logic               ebreakm_o
);

  csr_pkg::csr_data_t dcsr_q;  // fixed fields held at their values
  csr_pkg::csr_data_t dpc_q;
  csr_pkg::csr_data_t dscratch0_q;
  csr_pkg::csr_data_t dscratch1_q;

  // decode and read
  always_comb begin
    bus.d_hit   = 1'b1;
    bus.d_rdata = '0;
    case (bus.addr)
      csr_pkg::CSR_DCSR:      bus.d_rdata = dcsr_q;
      csr_pkg::CSR_DPC:       bus.d_rdata = dpc_q;
      csr_pkg::CSR_DSCRATCH0: bus.d_rdata = dscratch0_q;
      csr_pkg::CSR_DSCRATCH1: bus.d_rdata = dscratch1_q;
      default:                bus.d_hit   = 1'b0;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dcsr_q      <= csr_pkg::DCSR_FIXED;  // xdebugver=4, prv=m
      dpc_q       <= '0;
      dscratch0_q <= '0;
      dscratch1_q <= '0;
    end else begin
      if (trap.save_d) begin
        // debug entry overrides any bus write to dcsr/dpc
        dpc_q <= trap.exc_pc;
        dcsr_q[csr_pkg::DCSR_CAUSE_LSB +: 3] <= trap.dbg_cause;
      end else begin
        if (bus.we && bus.addr == csr_pkg::CSR_DCSR) begin
          dcsr_q <= (bus.wdata & csr_pkg::DCSR_WMASK) | csr_pkg::DCSR_FIXED;
        end
        // halfword aligned pcs only
        if (bus.we && bus.addr == csr_pkg::CSR_DPC && !bus.wdata[0]) begin
          dpc_q <= bus.wdata;
        end
      end
      if (bus.we && bus.addr == csr_pkg::CSR_DSCRATCH0) begin
        dscratch0_q <= bus.wdata;
      end
      if (bus.we && bus.addr == csr_pkg::CSR_DSCRATCH1) begin
        dscratch1_q <= bus.wdata;
      end
    end
  end

  assign depc_o        = dpc_q;
  assign single_step_o = dcsr_q[csr_pkg::DCSR_STEP_BIT];
  assign ebreakm_o     = dcsr_q[csr_pkg::DCSR_EBREAKM_BIT];

endmodule

// File: design/machine_csrs.sv
//////////////////////////////
// machine csr bank
// mstatus, mepc, mcause plus read-only mtvec, mhartid, misa
//////////////////////////////

`timescale 1ns/10ps

module machine_csrs (
  input  logic               clk,
  input  logic               rst_n,
  csr_bus_if.machine         bus,
  trap_if.machine            trap,
  input  logic [3:0]         core_id_i,
  input  logic [5:0]         cluster_id_i,
  input  csr_pkg::csr_data_t boot_addr_i,
  output logic               irq_enable_o,
  output csr_pkg::csr_data_t mepc_o
);

  logic                mie_q;     // mstatus.mie
  logic                mpie_q;    // mstatus.mpie
  csr_pkg::csr_data_t  mepc_q;
  csr_pkg::exc_cause_t mcause_q;
  csr_pkg::csr_data_t  mstatus_rd;

  // mpp is hardwired to m-mode
  always_comb begin
    mstatus_rd = '0;
    mstatus_rd[csr_pkg::MSTATUS_MIE_BIT]  = mie_q;
    mstatus_rd[csr_pkg::MSTATUS_MPIE_BIT] = mpie_q;
    mstatus_rd[csr_pkg::MSTATUS_MPP_LSB +: 2] = csr_pkg::PRIV_LVL_M;
  end

  //////////////////////////////
  // address decode and read
  //////////////////////////////

  always_comb begin
    bus.m_hit   = 1'b1;
    bus.m_rdata = '0;
    case (bus.addr)
      csr_pkg::CSR_MSTATUS: bus.m_rdata = mstatus_rd;
      csr_pkg::CSR_MISA:    bus.m_rdata = csr_pkg::MISA_VALUE;
      csr_pkg::CSR_MTVEC:   bus.m_rdata = {boot_addr_i[31:8], 8'h00};  // 256B aligned
      csr_pkg::CSR_MEPC:    bus.m_rdata = mepc_q;
      csr_pkg::CSR_MCAUSE:  bus.m_rdata = {mcause_q[5], 26'b0, mcause_q[4:0]};
      csr_pkg::CSR_MHARTID: bus.m_rdata = {21'b0, cluster_id_i, 1'b0, core_id_i};
      default:              bus.m_hit   = 1'b0;
    endcase
  end

  //////////////////////////////
  // registers
  //////////////////////////////

  // trap save first, then mret/dret, then the bus
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mie_q    <= 1'b0;
      mpie_q   <= 1'b0;
      mepc_q   <= '0;
      mcause_q <= '0;
    end else if (trap.save_m) begin
      mpie_q   <= mie_q;        // stack the enable
      mie_q    <= 1'b0;         // mask in the handler
      mepc_q   <= trap.exc_pc;
      mcause_q <= trap.cause;
    end else begin
      if (trap.restore) begin
        mie_q  <= mpie_q;
        mpie_q <= 1'b1;
      end else if (bus.we && bus.addr == csr_pkg::CSR_MSTATUS) begin
        mie_q  <= bus.wdata[csr_pkg::MSTATUS_MIE_BIT];
        mpie_q <= bus.wdata[csr_pkg::MSTATUS_MPIE_BIT];
      end
      if (bus.we && bus.addr == csr_pkg::CSR_MEPC) begin
        mepc_q <= bus.wdata;
      end
      if (bus.we && bus.addr == csr_pkg::CSR_MCAUSE) begin
        mcause_q <= {bus.wdata[31], bus.wdata[4:0]};  // flag + code only
      end
    end
  end

  assign irq_enable_o = mie_q;
  assign mepc_o       = mepc_q;

endmodule

// File: design/csr_ctrl.sv
//////////////////////////////
// csr control
// read mux, set/clear merge and trap routing
//////////////////////////////

`timescale 1ns/10ps

module csr_ctrl (
  csr_bus_if.ctrl              bus,
  trap_if.ctrl                 trap,
  input  csr_pkg::csr_op_e     csr_op_i,
  input  csr_pkg::csr_data_t   csr_wdata_i,        // write operand
  input  csr_pkg::csr_data_t   pc_if_i,
  input  csr_pkg::csr_data_t   pc_id_i,
  input  logic                 csr_save_if_i,
  input  logic                 csr_save_cause_i,
  input  logic                 debug_csr_save_i,
  input  csr_pkg::exc_cause_t  csr_cause_i,
  input  csr_pkg::dbg_cause_t  debug_cause_i,
  input  logic                 csr_restore_mret_i,
  input  logic                 csr_restore_dret_i,
  output csr_pkg::csr_data_t   csr_rdata_o
);

  //////////////////////////////
  // read side
  //////////////////////////////

  // banks decode disjoint ranges, so at most one hit
  always_comb begin
    if (bus.m_hit) begin
      csr_rdata_o = bus.m_rdata;
    end else if (bus.d_hit) begin
      csr_rdata_o = bus.d_rdata;
    end else if (bus.p_hit) begin
      csr_rdata_o = bus.p_rdata;
    end else begin
      csr_rdata_o = '0;  // unmapped reads as zero
    end
  end

  //////////////////////////////
  // write side
  //////////////////////////////

  always_comb begin
    unique case (csr_op_i)
      csr_pkg::CSR_OP_SET:   bus.wdata = csr_wdata_i | csr_rdata_o;
      csr_pkg::CSR_OP_CLEAR: bus.wdata = csr_rdata_o & ~csr_wdata_i;
      default:               bus.wdata = csr_wdata_i;  // write, none
    endcase
  end

  assign bus.we = (csr_op_i != csr_pkg::CSR_OP_NONE);

  //////////////////////////////
  // trap routing
  //////////////////////////////

  assign trap.exc_pc    = csr_save_if_i ? pc_if_i : pc_id_i;  // id pc by default
  assign trap.save_d    = csr_save_cause_i & debug_csr_save_i;
  assign trap.save_m    = csr_save_cause_i & ~debug_csr_save_i;
  assign trap.cause     = csr_cause_i;
  assign trap.dbg_cause = debug_cause_i;

  // save wins over a return in the same cycle
  assign trap.restore = (csr_restore_mret_i | csr_restore_dret_i) & ~csr_save_cause_i;

endmodule

// File: design/csr_if.sv
//////////////////////////////
// csr bus and trap interfaces
// bank access path and trap save/restore strobes
//////////////////////////////

`timescale 1ns/10ps

interface csr_bus_if;

  logic               access;  // real csr access this cycle
  csr_pkg::csr_addr_t addr;
  csr_pkg::csr_op_e   op;
  logic               we;      // any op but none
  csr_pkg::csr_data_t wdata;   // merged write data

  // per bank hit and read data
  logic               m_hit;
  csr_pkg::csr_data_t m_rdata;
  logic               d_hit;
  csr_pkg::csr_data_t d_rdata;
  logic               p_hit;
  csr_pkg::csr_data_t p_rdata;

  modport ctrl (
    output we, wdata,
    input  m_hit, m_rdata, d_hit, d_rdata, p_hit, p_rdata
  );

  modport machine (
    input  access, addr, we, wdata,
    output m_hit, m_rdata
  );

  modport debug (
    input  access, addr, we, wdata,
    output d_hit, d_rdata
  );

  modport perf (
    input  access, addr, we, wdata,
    output p_hit, p_rdata
  );

endinterface

interface trap_if;

  logic                save_m;     // trap entry to machine regs
  logic                save_d;     // trap entry to debug regs
  csr_pkg::csr_data_t  exc_pc;
  csr_pkg::exc_cause_t cause;
  csr_pkg::dbg_cause_t dbg_cause;
  logic                restore;    // mret or dret

  modport ctrl (output save_m, save_d, exc_pc, cause, dbg_cause, restore);

  modport machine (input save_m, exc_pc, cause, restore);

  modport debug (input save_d, exc_pc, dbg_cause);

endinterface

// File: design/csr_pkg.sv
//////////////////////////////
// csr package
// widths, csr numbers, field positions and fixed values
//////////////////////////////

package csr_pkg;

  typedef logic [31:0] csr_data_t;   // csr data word
  typedef logic [11:0] csr_addr_t;   // csr number
  typedef logic [1:0]  priv_lvl_t;
  typedef logic [5:0]  exc_cause_t;  // [5] irq flag, [4:0] code
  typedef logic [2:0]  dbg_cause_t;

  typedef enum logic [1:0] {
    CSR_OP_NONE  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  localparam priv_lvl_t PRIV_LVL_M = 2'd3;

  // csr numbers
  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MISA      = 12'h301;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_MHARTID   = 12'hF14;
  localparam csr_addr_t CSR_DCSR      = 12'h7B0;
  localparam csr_addr_t CSR_DPC       = 12'h7B1;
  localparam csr_addr_t CSR_DSCRATCH0 = 12'h7B2;
  localparam csr_addr_t CSR_DSCRATCH1 = 12'h7B3;
  localparam csr_addr_t CSR_PCER      = 12'h7A0;  // tselect slot
  localparam csr_addr_t CSR_PCMR      = 12'h7A1;  // tdata1 slot
  localparam csr_addr_t CSR_PCCR_BASE = 12'h780;
  localparam csr_addr_t CSR_PCCR_ALL  = 12'h79F;

  localparam csr_data_t MISA_VALUE    = 32'h4000_0104;  // mxl=1, I, C
  localparam logic [3:0] XDEBUGVER_STD = 4'd4;

  // perf counter bank
  localparam int N_PERF_COUNTERS = 6;
  typedef logic [N_PERF_COUNTERS-1:0] perf_mask_t;

  localparam int CNT_CYCLE  = 0;
  localparam int CNT_INSTR  = 1;
  localparam int CNT_LOAD   = 2;
  localparam int CNT_STORE  = 3;
  localparam int CNT_BRANCH = 4;
  localparam int CNT_TAKEN  = 5;

  localparam int PCMR_EN_BIT  = 0;
  localparam int PCMR_SAT_BIT = 1;
  localparam logic [1:0] PCMR_RESET = 2'd3;  // counting on, saturating

  // mstatus fields
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;  // 12:11

  // dcsr fields
  localparam int DCSR_XDEBUGVER_LSB = 28;
  localparam int DCSR_EBREAKM_BIT   = 15;
  localparam int DCSR_EBREAKS_BIT   = 13;
  localparam int DCSR_EBREAKU_BIT   = 12;
  localparam int DCSR_STEPIE_BIT    = 11;
  localparam int DCSR_CAUSE_LSB     = 6;   // 8:6
  localparam int DCSR_STEP_BIT      = 2;
  localparam int DCSR_PRV_LSB       = 0;   // 1:0

  // writable dcsr bits
  localparam csr_data_t DCSR_WMASK =
      (csr_data_t'(1) << DCSR_EBREAKM_BIT) |
      (csr_data_t'(1) << DCSR_EBREAKS_BIT) |
      (csr_data_t'(1) << DCSR_EBREAKU_BIT) |
      (csr_data_t'(1) << DCSR_STEPIE_BIT)  |
      (csr_data_t'(7) << DCSR_CAUSE_LSB)   |
      (csr_data_t'(1) << DCSR_STEP_BIT);

  // hardwired dcsr bits, also the reset value
  localparam csr_data_t DCSR_FIXED =
      (csr_data_t'(XDEBUGVER_STD) << DCSR_XDEBUGVER_LSB) |
      (csr_data_t'(PRIV_LVL_M) << DCSR_PRV_LSB);

endpackage
